//--- verilog/rename_pkg.sv
// ##########################################################################
// rename stage sizes, tag types and bus structs
// arch reg 31 is the zero register, always reads ready
// ##########################################################################

package rename_pkg;

  // machine sizes
  localparam int num_arch = 32;   // architectural registers
  localparam int num_pr   = 64;   // physical registers
  localparam int num_rob  = 16;   // reorder-buffer entries

  // index types
  typedef logic [$clog2(num_arch)-1:0] arch_idx_t;
  typedef logic [$clog2(num_pr)-1:0]   pr_idx_t;
  typedef logic [$clog2(num_rob)-1:0]  rob_idx_t;

  localparam arch_idx_t zero_reg = arch_idx_t'(num_arch - 1);  // hardwired zero

  // one map slot, phys tag plus ready
  typedef struct packed {
    pr_idx_t tag;
    logic    ready;
  } map_entry_t;

  // dispatched instruction, register fields only
  typedef struct packed {
    arch_idx_t dest;
    arch_idx_t src_a;
    arch_idx_t src_b;
  } dispatch_req_t;

  // completion bus, one broadcast per cycle
  typedef struct packed {
    logic      valid;
    pr_idx_t   tag;    // tag that completed
    arch_idx_t dest;   // arch reg it was written for
  } cdb_t;

  // everything the rename stage hands on per instruction
  typedef struct packed {
    map_entry_t t1;       // src_a tag, ready
    map_entry_t t2;       // src_b tag, ready
    pr_idx_t    t_new;    // fresh dest tag
    pr_idx_t    t_old;    // previous dest tag, freed at retire
    rob_idx_t   rob_idx;
  } rename_out_t;

  // squash back to a rob entry
  typedef struct packed {
    logic     valid;
    rob_idx_t idx;    // last entry that survives
  } rollback_t;

endpackage

//--- verilog/map_table.sv
// ##########################################################################
// checkpoints hold tags only, so a restored map reads all ready
// rollback assumed only once older instructions have completed
// ##########################################################################
`timescale 1ns/1ps

module map_table
  import rename_pkg::*;
(
  input  logic          clock,
  input  logic          reset,
  input  logic          dispatch_en,  // accepted dispatch this cycle
  input  dispatch_req_t req,
  input  pr_idx_t       t_new,        // from free list head
  input  rob_idx_t      rob_idx,      // rob tail, checkpoint slot
  input  cdb_t          cdb,
  input  rollback_t     rollback,
  output map_entry_t    t1,
  output map_entry_t    t2,
  output pr_idx_t       t_old
);

  map_entry_t map_q [num_arch];              // speculative map
  map_entry_t map_d [num_arch];
  pr_idx_t    ckpt_q [num_rob][num_arch];    // tags per rob entry
  logic       t_new_mapped;                  // t_new already live in map

  // source lookup with same-cycle cdb forwarding
  function automatic map_entry_t src_read(input map_entry_t e, input arch_idx_t src,
                                          input cdb_t bus);
    map_entry_t r;
    r = e;
    if (bus.valid && bus.tag == e.tag) begin
      r.ready = 1'b1;   // completing this cycle
    end
    if (src == zero_reg) begin
      r.ready = 1'b1;
    end
    return r;
  endfunction

  assign t1    = src_read(map_q[req.src_a], req.src_a, cdb);
  assign t2    = src_read(map_q[req.src_b], req.src_b, cdb);
  assign t_old = map_q[req.dest].tag;    // goes to rob, freed at retire

  // next map
  always_comb begin
    map_d = map_q;
    if (rollback.valid) begin
      // restore wins over wakeup and dispatch
      for (int i = 0; i < num_arch; i++) begin
        map_d[i].tag   = ckpt_q[rollback.idx][i];
        map_d[i].ready = 1'b1;   // older work assumed done
      end
    end else begin
      // wakeup only if the reg still maps that tag, stale ones ignored
      if (cdb.valid && map_q[cdb.dest].tag == cdb.tag) begin
        map_d[cdb.dest].ready = 1'b1;
      end
      if (dispatch_en) begin
        map_d[req.dest].tag   = t_new;
        map_d[req.dest].ready = (req.dest == zero_reg);  // zero reg stays ready
      end
    end
  end

  // map state
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < num_arch; i++) begin
        map_q[i].tag   <= pr_idx_t'(i);   // identity map
        map_q[i].ready <= 1'b1;
      end
    end else begin
      map_q <= map_d;
    end
  end

  // snapshot of the post-dispatch map, one per rob entry
  always_ff @(posedge clock) begin
    if (dispatch_en) begin
      for (int i = 0; i < num_arch; i++) begin
        ckpt_q[rob_idx][i] <= map_d[i].tag;
      end
    end
  end

  // is the incoming free tag still named by some arch reg
  always_comb begin
    t_new_mapped = 1'b0;
    for (int i = 0; i < num_arch; i++) begin
      if (map_q[i].tag == t_new) begin
        t_new_mapped = 1'b1;
      end
    end
  end

  // top level must hold dispatch off during a squash
  a_no_dispatch_on_rollback: assert property (
    @(posedge clock) disable iff (reset)
    rollback.valid |-> !dispatch_en
  ) else $error("dispatch accepted in rollback cycle");

  // free list and rob must never hand back a live tag
  a_t_new_unmapped: assert property (
    @(posedge clock) disable iff (reset)
    dispatch_en |-> !t_new_mapped
  ) else $error("t_new %0d is still mapped", t_new);

endmodule

//--- verilog/free_list.sv
// ##########################################################################
// 64-slot circular queue, holds tags 32..63 out of reset
// ##########################################################################
`timescale 1ns/1ps

module free_list
  import rename_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  logic      dispatch_en,   // pop head
  input  rob_idx_t  rob_idx,       // slot for the head checkpoint
  input  logic      free_valid,    // push at tail
  input  pr_idx_t   free_tag,
  input  rollback_t rollback,
  output pr_idx_t   t_new,
  output logic      fl_empty
);

  // pointer with wrap bit on top
  typedef logic [$bits(pr_idx_t):0] fl_ptr_t;

  pr_idx_t slot_q [num_pr];
  fl_ptr_t head_q;
  fl_ptr_t tail_q;
  fl_ptr_t count;
  fl_ptr_t head_ckpt [num_rob];   // head after each dispatch

  assign count    = tail_q - head_q;              // wrap bit keeps 64 apart from 0
  assign fl_empty = (count == '0);
  assign t_new    = slot_q[head_q[$bits(pr_idx_t)-1:0]];

  // pointers
  always_ff @(posedge clock) begin
    if (reset) begin
      head_q <= '0;
      tail_q <= fl_ptr_t'(num_arch);   // 32 tags queued
    end else begin
      if (rollback.valid) begin
        head_q <= head_ckpt[rollback.idx];   // squashed tags back in queue
      end else if (dispatch_en) begin
        head_q <= head_q + 1'b1;
      end
      // retire still pushes during a rollback
      if (free_valid) begin
        tail_q <= tail_q + 1'b1;
      end
    end
  end

  // slot i preloaded with tag i+32, upper half unused until wrap
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < num_pr; i++) begin
        slot_q[i] <= pr_idx_t'(i + num_arch);
      end
    end else if (free_valid) begin
      slot_q[tail_q[$bits(pr_idx_t)-1:0]] <= free_tag;
    end
  end

  // head checkpoint, the head just past this entry's tag
  always_ff @(posedge clock) begin
    if (dispatch_en) begin
      head_ckpt[rob_idx] <= head_q + 1'b1;
    end
  end

  // tags are conserved, so a full queue means a double free
  a_no_push_full: assert property (
    @(posedge clock) disable iff (reset)
    free_valid |-> (count != fl_ptr_t'(num_pr))
  ) else $error("free list overflow, tag %0d", free_tag);

endmodule

//--- verilog/rob_tags.sv
// ##########################################################################
// rob index allocation and T_old store, 16 entries
// completion of the head is decided outside, retire is a bare strobe
// ##########################################################################
`timescale 1ns/1ps

module rob_tags
  import rename_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  logic      dispatch_en,   // write at tail
  input  logic      retire,        // head done, dropped when empty
  input  pr_idx_t   t_old,
  input  rollback_t rollback,
  output rob_idx_t  rob_idx,
  output logic      rob_full,
  output logic      free_valid,
  output pr_idx_t   free_tag
);

  // pointer with wrap bit on top
  typedef logic [$bits(rob_idx_t):0] rob_ptr_t;

  pr_idx_t  told_q [num_rob];
  rob_ptr_t head_q;
  rob_ptr_t tail_q;
  rob_ptr_t count;
  rob_ptr_t rb_ptr;     // full pointer of the rollback entry
  rob_idx_t rb_off;     // its distance from head
  logic     rob_empty;

  assign count     = tail_q - head_q;
  assign rob_empty = (count == '0);
  assign rob_full  = (count == rob_ptr_t'(num_rob));
  assign rob_idx   = tail_q[$bits(rob_idx_t)-1:0];

  // retire hands T_old straight to the free list
  assign free_valid = retire && !rob_empty;
  assign free_tag   = told_q[head_q[$bits(rob_idx_t)-1:0]];

  // rebuild wrap bit for the rollback index
  assign rb_off = rollback.idx - head_q[$bits(rob_idx_t)-1:0];
  always_comb begin
    rb_ptr = {head_q[$bits(rob_idx_t)], rollback.idx};
    if (rollback.idx < head_q[$bits(rob_idx_t)-1:0]) begin
      rb_ptr[$bits(rob_idx_t)] = ~head_q[$bits(rob_idx_t)];  // past the wrap
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head_q <= '0;
      tail_q <= '0;
    end else begin
      if (free_valid) begin
        head_q <= head_q + 1'b1;
      end
      if (rollback.valid) begin
        tail_q <= rb_ptr + 1'b1;   // keep entry idx, drop younger
      end else if (dispatch_en) begin
        tail_q <= tail_q + 1'b1;
      end
    end
  end

  // T_old store, payload only
  always_ff @(posedge clock) begin
    if (dispatch_en) begin
      told_q[rob_idx] <= t_old;
    end
  end

  // rollback must name an in-flight entry
  a_rollback_in_window: assert property (
    @(posedge clock) disable iff (reset)
    rollback.valid |-> (rob_ptr_t'(rb_off) < count)
  ) else $error("rollback to idx %0d outside rob window", rollback.idx);

endmodule

//--- verilog/rename_unit.sv
// ##########################################################################
// rename stage top, one instruction per cycle, outputs combinational
// dispatch blocked while rollback is high, free list empty or rob full
// ##########################################################################
`timescale 1ns/1ps

module rename_unit
  import rename_pkg::*;
(
  input  logic          clock,
  input  logic          reset,
  input  logic          dispatch_valid,
  input  dispatch_req_t dispatch_req,
  input  cdb_t          cdb,
  input  logic          retire,
  input  rollback_t     rollback,
  output logic          dispatch_ready,
  output rename_out_t   rename_out
);

  logic       dispatch_en;
  logic       fl_empty;
  logic       rob_full;
  logic       free_valid;
  pr_idx_t    free_tag;
  pr_idx_t    t_new;
  pr_idx_t    t_old;
  rob_idx_t   rob_idx;
  map_entry_t t1;
  map_entry_t t2;

  // accept only with a free tag, a rob slot and no squash
  assign dispatch_ready = !fl_empty && !rob_full && !rollback.valid;
  assign dispatch_en    = dispatch_valid && dispatch_ready;

  map_table u_map_table (
    .clock       (clock),
    .reset       (reset),
    .dispatch_en (dispatch_en),
    .req         (dispatch_req),
    .t_new       (t_new),
    .rob_idx     (rob_idx),
    .cdb         (cdb),
    .rollback    (rollback),
    .t1          (t1),
    .t2          (t2),
    .t_old       (t_old)
  );

  free_list u_free_list (
    .clock       (clock),
    .reset       (reset),
    .dispatch_en (dispatch_en),
    .rob_idx     (rob_idx),
    .free_valid  (free_valid),   // retired T_old
    .free_tag    (free_tag),
    .rollback    (rollback),
    .t_new       (t_new),
    .fl_empty    (fl_empty)
  );

  rob_tags u_rob_tags (
    .clock       (clock),
    .reset       (reset),
    .dispatch_en (dispatch_en),
    .retire      (retire),
    .t_old       (t_old),
    .rollback    (rollback),
    .rob_idx     (rob_idx),
    .rob_full    (rob_full),
    .free_valid  (free_valid),
    .free_tag    (free_tag)
  );

  // same-cycle result for the dispatching instruction
  assign rename_out = '{t1: t1, t2: t2, t_new: t_new, t_old: t_old, rob_idx: rob_idx};

endmodule

//--- verification/tb_rename_unit.sv
// ##########################################################################
// expected tags follow the reset map and free-list order of a fixed table
// stall rows check only the first dispatch of the burst plus the count
// ##########################################################################
`timescale 1ns/1ps

module tb_rename_unit
  import rename_pkg::*;
();

  localparam logic [2:0] op_disp     = 3'd0;
  localparam logic [2:0] op_cdb      = 3'd1;
  localparam logic [2:0] op_retire   = 3'd2;
  localparam logic [2:0] op_rollback = 3'd3;
  localparam logic [2:0] op_stall    = 3'd4;   // dispatch until ready drops
  localparam int         wait_limit  = 64;     // cycles per wait loop

  typedef struct packed {
    logic [2:0]    op;
    dispatch_req_t req;
    logic          cdb_valid;
    pr_idx_t       cdb_tag;
    arch_idx_t     cdb_dest;
    logic [4:0]    count;       // retire strobes, rollback idx or burst length
    rename_out_t   exp;         // rename outputs before the (first) accept
    logic          exp_ready;   // dispatch_ready after the row
  } op_row_t;

  logic          clock;
  logic          reset;
  logic          dispatch_valid;
  dispatch_req_t dispatch_req;
  cdb_t          cdb;
  logic          retire;
  rollback_t     rollback;
  logic          dispatch_ready;
  rename_out_t   rename_out;

  op_row_t rows [$];
  int      error_count;
  int      check_count;
  int      row_errors;
  logic    timed_out;

  rename_unit DUT (
    .clock          (clock),
    .reset          (reset),
    .dispatch_valid (dispatch_valid),
    .dispatch_req   (dispatch_req),
    .cdb            (cdb),
    .retire         (retire),
    .rollback       (rollback),
    .dispatch_ready (dispatch_ready),
    .rename_out     (rename_out)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;   // 40 ns period
  end

  task automatic add_row(input logic [2:0] op, input int dest, input int src_a,
                         input int src_b, input int cdb_v, input int cdb_tag,
                         input int cdb_dest, input int count, input int t1, input int r1,
                         input int t2, input int r2, input int t_old, input int t_new,
                         input int rob, input int rdy);
    op_row_t r;
    r              = '0;
    r.op           = op;
    r.req.dest     = arch_idx_t'(dest);
    r.req.src_a    = arch_idx_t'(src_a);
    r.req.src_b    = arch_idx_t'(src_b);
    r.cdb_valid    = (cdb_v != 0);
    r.cdb_tag      = pr_idx_t'(cdb_tag);
    r.cdb_dest     = arch_idx_t'(cdb_dest);
    r.count        = 5'(count);
    r.exp.t1.tag   = pr_idx_t'(t1);
    r.exp.t1.ready = (r1 != 0);
    r.exp.t2.tag   = pr_idx_t'(t2);
    r.exp.t2.ready = (r2 != 0);
    r.exp.t_old    = pr_idx_t'(t_old);
    r.exp.t_new    = pr_idx_t'(t_new);
    r.exp.rob_idx  = rob_idx_t'(rob);
    r.exp_ready    = (rdy != 0);
    rows.push_back(r);
  endtask

  task automatic build_table();
    //      op           dst sa  sb cv ctag cd  n  t1 r  t2 r old new rob rdy
    add_row(op_disp,      1,  2,  3, 0,  0,  0,  0,  2, 1,  3, 1,  1, 32, 0, 1);
    add_row(op_disp,      2,  1, 31, 0,  0,  0,  0, 32, 0, 31, 1,  2, 33, 1, 1);
    add_row(op_disp,     31,  5,  6, 0,  0,  0,  0,  5, 1,  6, 1, 31, 34, 2, 1);
    add_row(op_disp,      3, 31,  2, 0,  0,  0,  0, 34, 1, 33, 0,  3, 35, 3, 1);
    add_row(op_disp,      4,  1,  2, 1, 32,  1,  0, 32, 1, 33, 0,  4, 36, 4, 1);  // forwarding
    add_row(op_cdb,       0,  0,  0, 1,  2,  2,  0,  0, 0,  0, 0,  0,  0, 0, 1);  // stale tag
    add_row(op_disp,      5,  1,  2, 0,  0,  0,  0, 32, 1, 33, 0,  5, 37, 5, 1);
    add_row(op_rollback,  0,  0,  0, 0,  0,  0,  3,  0, 0,  0, 0,  0,  0, 0, 1);
    add_row(op_disp,      6,  1,  3, 0,  0,  0,  0, 32, 1, 35, 1,  6, 36, 4, 1);  // all ready
    add_row(op_disp,      7,  4,  5, 0,  0,  0,  0,  4, 1,  5, 1,  7, 37, 5, 1);
    add_row(op_stall,     8,  6,  7, 0,  0,  0, 10, 36, 0, 37, 0,  8, 38, 6, 0);  // rob full
    add_row(op_retire,    0,  0,  0, 0,  0,  0,  1,  0, 0,  0, 0,  0,  0, 0, 1);
    add_row(op_retire,    0,  0,  0, 0,  0,  0, 15,  0, 0,  0, 0,  0,  0, 0, 1);
    add_row(op_stall,     9,  8,  0, 0,  0,  0, 16, 47, 0,  0, 1,  9, 48, 0, 0);
    add_row(op_retire,    0,  0,  0, 0,  0,  0,  1,  0, 0,  0, 0,  0,  0, 0, 1);
    add_row(op_disp,     10,  9, 31, 0,  0,  0,  0, 63, 0, 34, 1, 10,  1, 0, 1);  // tag 1 back
  endtask

  function automatic string op_name(input logic [2:0] op);
    case (op)
      op_disp:     return "dispatch";
      op_cdb:      return "cdb";
      op_retire:   return "retire";
      op_rollback: return "rollback";
      op_stall:    return "dispatch until stall";
      default:     return "unknown";
    endcase
  endfunction

  task automatic next_cycle();
    @(posedge clock);
    #2;   // inputs move just after the edge
  endtask

  task automatic clear_inputs();
    dispatch_valid = 1'b0;
    dispatch_req   = '0;
    cdb            = '0;
    retire         = 1'b0;
    rollback       = '0;
  endtask

  task automatic compare_field(input string name, input string field, input int expected,
                               input int actual);
    check_count++;
    if (actual != expected) begin
      $display("Error %s %s: expected %0d, actual %0d", name, field, expected, actual);
      error_count++;
      row_errors++;
    end
  endtask

  task automatic check_rename(input string name, input op_row_t r);
    compare_field(name, "t1 tag", int'(r.exp.t1.tag), int'(rename_out.t1.tag));
    compare_field(name, "t1 ready", int'(r.exp.t1.ready), int'(rename_out.t1.ready));
    compare_field(name, "t2 tag", int'(r.exp.t2.tag), int'(rename_out.t2.tag));
    compare_field(name, "t2 ready", int'(r.exp.t2.ready), int'(rename_out.t2.ready));
    compare_field(name, "t_old", int'(r.exp.t_old), int'(rename_out.t_old));
    compare_field(name, "t_new", int'(r.exp.t_new), int'(rename_out.t_new));
    compare_field(name, "rob_idx", int'(r.exp.rob_idx), int'(rename_out.rob_idx));
  endtask

  // identity map read with dispatch idle
  task automatic sweep_reset_map();
    for (int k = 0; k < num_arch; k++) begin
      dispatch_req.src_a = arch_idx_t'(k);
      dispatch_req.src_b = arch_idx_t'(num_arch - 1 - k);
      @(negedge clock);
      compare_field("reset map", "t1 tag", k, int'(rename_out.t1.tag));
      compare_field("reset map", "t1 ready", 1, int'(rename_out.t1.ready));
      compare_field("reset map", "t2 tag", num_arch - 1 - k, int'(rename_out.t2.tag));
      compare_field("reset map", "t2 ready", 1, int'(rename_out.t2.ready));
      compare_field("reset map", "dispatch_ready", 1, int'(dispatch_ready));
      next_cycle();
    end
    clear_inputs();
  endtask

  task automatic dispatch_one(input string name, input op_row_t r);
    int waited;
    waited         = 0;
    dispatch_valid = 1'b1;
    dispatch_req   = r.req;
    cdb.valid      = r.cdb_valid;   // same-cycle broadcast
    cdb.tag        = r.cdb_tag;
    cdb.dest       = r.cdb_dest;
    @(negedge clock);
    compare_field(name, "dispatch_ready", int'(r.exp_ready), int'(dispatch_ready));
    while (!dispatch_ready) begin   // valid held while stalled
      if (waited == wait_limit) begin
        $display("%s: dispatch_ready stayed low for %0d cycles", name, wait_limit);
        timed_out = 1'b1;
        error_count++;
        break;
      end
      next_cycle();
      @(negedge clock);
      waited++;
    end
    if (!timed_out) begin
      check_rename(name, r);
    end
    next_cycle();   // accepting edge
    clear_inputs();
  endtask

  task automatic dispatch_until_stall(input string name, input op_row_t r);
    int accepted;
    accepted       = 0;
    dispatch_valid = 1'b1;
    dispatch_req   = r.req;   // same dest every time
    @(negedge clock);
    check_rename(name, r);
    while (dispatch_ready) begin
      if (accepted == wait_limit) begin
        $display("%s: dispatch_ready never dropped after %0d dispatches", name, wait_limit);
        timed_out = 1'b1;
        error_count++;
        break;
      end
      next_cycle();
      accepted++;
      @(negedge clock);
    end
    compare_field(name, "dispatches", int'(r.count), accepted);
    compare_field(name, "dispatch_ready", int'(r.exp_ready), int'(dispatch_ready));
    next_cycle();
    clear_inputs();
  endtask

  // cdb, retire and rollback strobes followed by one idle cycle
  task automatic pulse_strobe(input string name, input op_row_t r);
    int cycles;
    cycles         = (r.op == op_retire) ? int'(r.count) : 1;
    cdb.valid      = (r.op == op_cdb);
    cdb.tag        = r.cdb_tag;
    cdb.dest       = r.cdb_dest;
    retire         = (r.op == op_retire);
    rollback.valid = (r.op == op_rollback);
    rollback.idx   = rob_idx_t'(r.count);
    if (r.op == op_rollback) begin
      @(negedge clock);
      compare_field(name, "ready during rollback", 0, int'(dispatch_ready));
    end
    repeat (cycles) next_cycle();
    clear_inputs();
    @(negedge clock);
    compare_field(name, "dispatch_ready", int'(r.exp_ready), int'(dispatch_ready));
    next_cycle();
  endtask

  initial begin : run_table
    op_row_t r;
    string   name;
    int      done;
    error_count = 0;
    check_count = 0;
    row_errors  = 0;
    timed_out   = 1'b0;
    done        = 0;
    reset       = 1'b1;
    clear_inputs();
    build_table();
    repeat (4) @(posedge clock);
    #2;
    reset = 1'b0;
    sweep_reset_map();
    $display("reset map: %0d mismatches", row_errors);
    for (int i = 0; i < rows.size() && !timed_out; i++) begin
      r          = rows[i];
      name       = $sformatf("row %0d %s", i, op_name(r.op));
      row_errors = 0;
      case (r.op)
        op_disp:  dispatch_one(name, r);
        op_stall: dispatch_until_stall(name, r);
        default:  pulse_strobe(name, r);
      endcase
      done++;
      if (timed_out) begin
        $display("%s: stopped after a timeout", name);
      end else begin
        $display("%s: %0d mismatches", name, row_errors);
      end
    end
    $display("rows %0d of %0d, checks %0d, errors %0d", done, rows.size(), check_count,
             error_count);
    if (error_count == 0 && !timed_out) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- rename_unit.f
verilog/rename_pkg.sv
verilog/map_table.sv
verilog/free_list.sv
verilog/rob_tags.sv
verilog/rename_unit.sv
verification/tb_rename_unit.sv

//--- Makefile
# Verilator build and run for the rename stage testbench

TOP = tb_rename_unit

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): rename_unit.f $(shell cat rename_unit.f)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f rename_unit.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "sim failed" sim.log; then exit 1; fi
	@grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log
